// File: Makefile
# ems page mapper simulation with verilator

OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_ems -f build.f \
		--Mdir $(OBJ_DIR) -o tb_ems_sim
	./$(OBJ_DIR)/tb_ems_sim

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
logic/ems_pkg.sv
logic/ems_regs.sv
logic/ems_page_window.sv
logic/ems_addr_merge.sv
logic/ems_top.sv
testbench/tb_ems.sv

// File: logic/ems_addr_merge.sv
// ems address merge: folds window hits into a translated or pass-through sdram address
`timescale 1ns/100ps

module ems_addr_merge (
  // one result per window
  input  ems_pkg::ems_map_t [ems_pkg::ems_num_pages-1:0] map_i,
  // cpu memory address
  input  logic [19:1]                                    sdram_adr_i,
  // sdram byte address
  output logic [31:0]                                    sdram_adr_o
);

  import ems_pkg::*;

  logic      hit_any;
  ems_page_t hit_page;

  // and-or select
  // windows cover disjoint pages so at most one hits
  always_comb
  begin
    hit_any  = 1'b0;
    hit_page = '0;
    for (int i = 0; i < ems_num_pages; i++)
    begin
      hit_any  = hit_any | map_i[i].hit;
      hit_page = hit_page | (map_i[i].page & {$bits(ems_page_t){map_i[i].hit}});
    end
  end

  // translated form
  // page on top of the 16 KB offset, upper bits zero
  // unmapped form
  // cpu address widened to 32 bits
  always_comb
  begin
    if (hit_any)
    begin
      sdram_adr_o = {9'b0, hit_page, sdram_adr_i[13:1], 2'b00};
    end
    else
    begin
      sdram_adr_o = {11'b0, sdram_adr_i[19:1], 2'b00};
    end
  end

endmodule

// File: logic/ems_page_window.sv
// ems page window: one 16 KB page register plus its frame hit test
`timescale 1ns/100ps

module ems_page_window #(
  parameter int PAGE_IDX = 0
) (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  // from the register block
  input  ems_pkg::ems_ctrl_t    ctrl_i,
  input  ems_pkg::ems_page_wr_t page_wr_i,
  // cpu memory address
  input  logic [19:1]           sdram_adr_i,
  // to the merge and back to readback
  output ems_pkg::ems_map_t     map_o,
  output ems_pkg::ems_page_t    page_o
);

  import ems_pkg::*;

  ems_page_t page_q;
  logic      in_frame;
  logic      in_page;

  // page register, loads on its own strobe only
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      page_q <= '0;
    end
    else if (page_wr_i.wr_en[PAGE_IDX])
    begin
      page_q <= page_wr_i.wr_data;
    end
  end

  // 64 KB frame match on bits 19:16
  assign in_frame = (sdram_adr_i[19:16] == ctrl_i.umb_base);

  // which quarter of the frame
  assign in_page = (sdram_adr_i[15:14] == 2'(PAGE_IDX));

  // hit only while mapping is on
  assign map_o.hit  = ctrl_i.enable && in_frame && in_page;
  assign map_o.page = page_q;

  assign page_o = page_q;

endmodule

// File: logic/ems_pkg.sv
// ems page mapper shared types: page count, register opcode and inter-block structs
package ems_pkg;

  // pages in the 64 KB upper-memory frame
  // fixed by cpu address bits 15:14
  localparam int ems_num_pages = 4;

  // sdram page number of a 16 KB block
  // covers mapped addresses up to 4 MB
  typedef logic [7:0] ems_page_t;

  // register kind, taken from wb address bit 2
  typedef enum logic
  {
    REG_PAGE = 1'b0,
    REG_CTRL = 1'b1
  } ems_reg_kind_e;

  // control register contents, broadcast to every window
  typedef struct packed
  {
    // mapping on/off
    logic       enable;
    // frame base, cpu address bits 19:16
    logic [3:0] umb_base;
  } ems_ctrl_t;

  // page register write bus
  // one strobe per page, shared data byte
  typedef struct packed
  {
    logic [ems_num_pages-1:0] wr_en;
    ems_page_t                wr_data;
  } ems_page_wr_t;

  // per-window translation result
  typedef struct packed
  {
    // address falls in this window's page
    logic      hit;
    // stored sdram page for that window
    ems_page_t page;
  } ems_map_t;

endpackage

// File: logic/ems_regs.sv
// ems register block: wishbone i/o slave holding enable, frame base and page write steering
`timescale 1ns/100ps

module ems_regs #(
  parameter logic [15:0] IO_BASE_ADDR = 16'h0208
) (
  input  logic                                          wb_clk_i,
  input  logic                                          wb_rst_i,
  // wishbone slave
  input  logic [15:1]                                   wb_adr_i,
  input  logic [15:0]                                   wb_dat_i,
  output logic [15:0]                                   wb_dat_o,
  input  logic [1:0]                                    wb_sel_i,
  input  logic                                          wb_cyc_i,
  input  logic                                          wb_stb_i,
  input  logic                                          wb_we_i,
  output logic                                          wb_ack_o,
  output logic                                          ems_io_area_o,
  // stored pages coming back from the windows
  input  ems_pkg::ems_page_t [ems_pkg::ems_num_pages-1:0] page_rd_i,
  // to the windows
  output ems_pkg::ems_ctrl_t                            ctrl_o,
  output ems_pkg::ems_page_wr_t                         page_wr_o
);

  import ems_pkg::*;

  // decoded access
  ems_reg_kind_e reg_kind;
  logic [1:0]    page_sel;
  logic          io_access;
  logic          io_write;

  // byte seen on the selected lane
  logic [7:0]    wr_byte;

  // read side
  logic [7:0]    rd_byte;

  // enable and frame base
  ems_ctrl_t     ctrl_q;

  // i/o window is eight bytes, compare bits 15:3 only
  assign ems_io_area_o = (wb_adr_i[15:3] == IO_BASE_ADDR[15:3]);

  // bit 2 picks page regs or control reg
  assign reg_kind = wb_adr_i[2] ? REG_CTRL : REG_PAGE;

  // page index, address bit 1 high, lane select low
  assign page_sel = {wb_adr_i[1], wb_sel_i[0]};

  assign io_access = wb_cyc_i && wb_stb_i && ems_io_area_o;
  assign io_write  = io_access && wb_we_i;

  // 8-bit i/o only
  // sel[0] set means even byte on the low lane
  assign wr_byte = wb_sel_i[0] ? wb_dat_i[7:0] : wb_dat_i[15:8];

  // control register
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      ctrl_q <= '0;
    end
    else if (io_write && (reg_kind == REG_CTRL))
    begin
      // enable in bit 7, base in the low nibble
      ctrl_q.enable   <= wr_byte[7];
      ctrl_q.umb_base <= wr_byte[3:0];
    end
  end

  assign ctrl_o = ctrl_q;

  // page writes become a one-hot strobe
  // the owning window latches on the same edge
  always_comb
  begin
    page_wr_o.wr_en   = '0;
    page_wr_o.wr_data = wr_byte;
    if (io_write && (reg_kind == REG_PAGE))
    begin
      page_wr_o.wr_en[page_sel] = 1'b1;
    end
  end

  // read mux, combinational
  always_comb
  begin
    case (reg_kind)
      REG_PAGE: rd_byte = page_rd_i[page_sel];
      REG_CTRL: rd_byte = {ctrl_q.enable, 3'b000, ctrl_q.umb_base};
      default:  rd_byte = 8'h00;
    endcase
  end

  // same byte on both lanes
  // master picks whichever lane it asked for
  assign wb_dat_o = {rd_byte, rd_byte};

  // ack one cycle after the strobe
  // a held strobe acks every cycle, no stall
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      wb_ack_o <= 1'b0;
    end
    else
    begin
      wb_ack_o <= io_access;
    end
  end

endmodule

// File: logic/ems_top.sv
// ems subsystem top: register block, four page windows and the address merge
`timescale 1ns/100ps

module ems_top #(
  parameter logic [15:0] IO_BASE_ADDR = 16'h0208
) (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  // wishbone slave, 8-bit i/o registers
  input  logic [15:1] wb_adr_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  input  logic [1:0]  wb_sel_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  output logic        wb_ack_o,
  output logic        ems_io_area_o,
  // sdram address path
  input  logic [19:1] sdram_adr_i,
  output logic [31:0] sdram_adr_o
);

  import ems_pkg::*;

  // register block to windows
  ems_ctrl_t    ctrl;
  ems_page_wr_t page_wr;

  // windows back to readback and merge
  ems_page_t [ems_num_pages-1:0] page_rd;
  ems_map_t  [ems_num_pages-1:0] map;

  ems_regs #(
    .IO_BASE_ADDR (IO_BASE_ADDR)
  ) u_regs (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_sel_i      (wb_sel_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_ack_o      (wb_ack_o),
    .ems_io_area_o (ems_io_area_o),
    .page_rd_i     (page_rd),
    .ctrl_o        (ctrl),
    .page_wr_o     (page_wr)
  );

  // one window per 16 KB page of the frame
  for (genvar i = 0; i < ems_num_pages; i++)
  begin : g_win
    ems_page_window #(
      .PAGE_IDX (i)
    ) u_win (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .ctrl_i      (ctrl),
      .page_wr_i   (page_wr),
      .sdram_adr_i (sdram_adr_i),
      .map_o       (map[i]),
      .page_o      (page_rd[i])
    );
  end

  // final sdram address
  ems_addr_merge u_merge (
    .map_i       (map),
    .sdram_adr_i (sdram_adr_i),
    .sdram_adr_o (sdram_adr_o)
  );

endmodule

// File: testbench/tb_ems.sv
// ems page mapper testbench: directed register, decode and address mapping tests
`timescale 1ns/100ps

module tb_ems;

  import ems_pkg::*;

  localparam logic [15:0] io_base = 16'h0208;
  localparam int addr_per_page = 4;
  // cycle budget, two cycles per bus access plus one per address check
  localparam int reset_cycles = 5;
  localparam int num_accesses = 30;
  localparam int num_adr_checks = addr_per_page * ems_num_pages * 2 + 10;
  localparam int test_cycles = reset_cycles + 2 * num_accesses + num_adr_checks;

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic [15:1] wb_adr_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic [1:0]  wb_sel_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic        wb_ack_o;
  logic        ems_io_area_o;
  logic [19:1] sdram_adr_i;
  logic [31:0] sdram_adr_o;

  // lcg state
  logic [31:0] seed;

  // expected register contents
  ems_page_t   page_model [ems_num_pages];
  logic        en_model;
  logic [3:0]  base_model;

  ems_top #(
    .IO_BASE_ADDR (io_base)
  ) uut (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_sel_i      (wb_sel_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_ack_o      (wb_ack_o),
    .ems_io_area_o (ems_io_area_o),
    .sdram_adr_i   (sdram_adr_i),
    .sdram_adr_o   (sdram_adr_o)
  );

  always #5 wb_clk_i = ~wb_clk_i;

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check_dat(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp)
    begin
      $display("error: %s got %h expected %h", name, got, exp);
      $display("tests failed");
      $fatal(1, "read data mismatch");
    end
  endtask

  task automatic check_adr(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error: %s got %h expected %h", name, got, exp);
      $display("tests failed");
      $fatal(1, "sdram address mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("error: %s got %h expected %h", name, got, exp);
      $display("tests failed");
      $fatal(1, "status bit mismatch");
    end
  endtask

  // page p sits at bit 1 of the address and on lane sel[0]
  function automatic logic [15:0] page_addr(input int p);
    return {io_base[15:3], 1'b0, p[1], 1'b0};
  endfunction

  function automatic logic [1:0] page_lane(input int p);
    return p[0] ? 2'b01 : 2'b10;
  endfunction

  // hit rule or pass-through rule, from the model registers
  function automatic logic [31:0] expect_adr(input logic [19:1] a);
    if (en_model && (a[19:16] == base_model))
    begin
      return {9'b0, page_model[a[15:14]], a[13:1], 2'b00};
    end
    return {11'b0, a[19:1], 2'b00};
  endfunction

  // one strobe cycle, then the ack cycle
  task automatic bus_cycle(input logic we, input logic [15:0] addr, input logic [1:0] sel,
                           input logic [15:0] dat, input logic in_area,
                           output logic [15:0] rd);
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= addr[15:1];
    wb_sel_i <= sel;
    wb_dat_i <= dat;
    @(negedge wb_clk_i);
    // read data and decode already valid, ack not yet
    rd = wb_dat_o;
    check_bit("ems_io_area_o", ems_io_area_o, in_area);
    check_bit("wb_ack_o", wb_ack_o, 1'b0);
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    @(negedge wb_clk_i);
    if (in_area && (wb_ack_o !== 1'b1))
    begin
      $display("no acknowledge one cycle after the strobe to address %h", addr);
      $display("tests failed");
      $fatal(1, "missing acknowledge");
    end
    else if (!in_area)
    begin
      check_bit("wb_ack_o", wb_ack_o, 1'b0);
    end
  endtask

  task automatic write_reg(input logic [15:0] addr, input logic [1:0] sel, input logic [7:0] b);
    logic [15:0] rd;
    // unused lane carries the complement
    bus_cycle(1'b1, addr, sel, sel[0] ? {~b, b} : {b, ~b}, 1'b1, rd);
  endtask

  task automatic read_reg(input logic [15:0] addr, input logic [1:0] sel, input logic [7:0] b);
    logic [15:0] rd;
    bus_cycle(1'b0, addr, sel, 16'h0000, 1'b1, rd);
    check_dat("wb_dat_o", rd, {b, b});
  endtask

  task automatic write_page(input int p, input ems_page_t b);
    write_reg(page_addr(p), page_lane(p), b);
    page_model[p] = b;
  endtask

  task automatic write_ctrl(input logic en, input logic [3:0] base);
    logic [31:0] r;
    r = next_random();
    // bits 6:4 are junk and must read back zero
    write_reg({io_base[15:3], 3'b100}, 2'b01, {en, r[6:4], base});
    en_model   = en;
    base_model = base;
  endtask

  task automatic read_all();
    for (int p = 0; p < ems_num_pages; p++)
    begin
      read_reg(page_addr(p), page_lane(p), page_model[p]);
    end
    read_reg({io_base[15:3], 3'b100}, 2'b01, {en_model, 3'b000, base_model});
  endtask

  task automatic check_sdram(input logic [19:1] a);
    @(posedge wb_clk_i);
    sdram_adr_i <= a;
    @(negedge wb_clk_i);
    check_adr("sdram_adr_o", sdram_adr_o, expect_adr(a));
  endtask

  task automatic test_reset_state();
    @(negedge wb_clk_i);
    check_bit("wb_ack_o", wb_ack_o, 1'b0);
    read_all();
  endtask

  task automatic test_reg_readback();
    logic [31:0] r;
    for (int p = 0; p < ems_num_pages; p++)
    begin
      r = next_random();
      write_page(p, r[15:8]);
    end
    r = next_random();
    write_ctrl(r[20], r[11:8]);
    read_all();
  endtask

  task automatic test_io_decode();
    logic [31:0] r;
    logic [15:0] addr;
    logic [15:0] rd;
    r = next_random();
    addr = {r[15:1], 1'b0};
    // force a miss on bits 15:3
    if (addr[15:3] == io_base[15:3])
    begin
      addr[8] = ~addr[8];
    end
    bus_cycle(1'b1, addr, 2'b01, r[31:16], 1'b0, rd);
    bus_cycle(1'b0, addr, 2'b10, 16'h0000, 1'b0, rd);
    read_all();
  endtask

  task automatic test_mapping();
    logic [31:0] r;
    r = next_random();
    write_ctrl(1'b1, r[19:16]);
    for (int p = 0; p < ems_num_pages; p++)
    begin
      r = next_random();
      write_page(p, r[23:16]);
    end
    for (int p = 0; p < ems_num_pages; p++)
    begin
      for (int k = 0; k < addr_per_page; k++)
      begin
        r = next_random();
        check_sdram({base_model, p[1:0], r[13:1]});
      end
    end
    // other frames, nibble forced to differ
    for (int k = 0; k < 2 * addr_per_page; k++)
    begin
      r = next_random();
      check_sdram({base_model ^ (r[31:28] | 4'h1), r[17:3]});
    end
  endtask

  task automatic test_disable();
    logic [31:0] r;
    write_ctrl(1'b0, base_model);
    for (int p = 0; p < ems_num_pages; p++)
    begin
      for (int k = 0; k < addr_per_page; k++)
      begin
        r = next_random();
        check_sdram({base_model, p[1:0], r[13:1]});
      end
    end
    r = next_random();
    check_sdram({base_model, r[15:14], r[13:1]});
    write_ctrl(1'b1, base_model);
    // cycle after the write edge, address still held
    check_adr("sdram_adr_o", sdram_adr_o, expect_adr(sdram_adr_i));
  endtask

  // watchdog
  initial
  begin
    repeat (test_cycles * 2) @(posedge wb_clk_i);
    $display("watchdog expired, the tests ran longer than %0d cycles", test_cycles * 2);
    $display("tests failed");
    $fatal(1, "timeout");
  end

  initial
  begin
    seed        = 32'h3454_f92f;
    en_model    = 1'b0;
    base_model  = 4'h0;
    for (int p = 0; p < ems_num_pages; p++)
    begin
      page_model[p] = '0;
    end
    wb_clk_i    = 1'b0;
    wb_rst_i    = 1'b1;
    wb_adr_i    = '0;
    wb_dat_i    = '0;
    wb_sel_i    = '0;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    wb_we_i     = 1'b0;
    sdram_adr_i = '0;
    repeat (4) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    test_reset_state();
    test_reg_readback();
    test_io_decode();
    test_mapping();
    test_disable();
    $display("all tests passed");
    $finish;
  end

endmodule
